// ==== source/md_pkg.sv ====
`default_nettype none

package md_pkg;

  // Operations shared by the multiplier and the divider
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // One operand or one result
  typedef logic [31:0] md_word_t;

  // Bit 0 marks operand A as signed, bit 1 marks operand B as signed
  typedef logic [1:0] md_sign_t;

  // Divider bit index
  localparam int unsigned MD_DIV_CNT_W = 5;
  typedef logic [MD_DIV_CNT_W-1:0] md_div_cnt_t;

  // Cycles from the accepting edge to the valid pulse of a full division
  localparam int unsigned MD_DIV_LATENCY = 36;

endpackage

`default_nettype wire

// ==== source/md_req_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Shared operand bus that is only meaningful while the matching enable is high
interface md_req_if;

  md_pkg::md_op_e   op;
  md_pkg::md_sign_t sign_mode;
  md_pkg::md_word_t op_a;
  md_pkg::md_word_t op_b;

  modport src (
    output op,
    output sign_mode,
    output op_a,
    output op_b
  );

  modport dst (
    input op,
    input sign_mode,
    input op_a,
    input op_b
  );

endinterface

`default_nettype wire

// ==== source/md_mult.sv ====
`timescale 1ns/1ns
`default_nettype none

module md_mult (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             mult_en_i,
  md_req_if.dst            req,
  output md_pkg::md_word_t mult_result_o,
  output logic             mult_valid_o
);

  logic               sign_a;
  logic               sign_b;
  logic signed [16:0] a_part [2];
  logic signed [8:0]  b_part [4];
  logic signed [25:0] pp_q   [8];
  md_pkg::md_op_e     op_q;
  logic        [63:0] product;

  assign sign_a = req.op_a[31] & req.sign_mode[0];
  assign sign_b = req.op_b[31] & req.sign_mode[1];

  // A in two 17-bit halves, B in four 9-bit bytes; only the top pieces carry a sign
  assign a_part[0] = {1'b0, req.op_a[15:0]};
  assign a_part[1] = {sign_a, req.op_a[31:16]};
  assign b_part[0] = {1'b0, req.op_b[7:0]};
  assign b_part[1] = {1'b0, req.op_b[15:8]};
  assign b_part[2] = {1'b0, req.op_b[23:16]};
  assign b_part[3] = {sign_b, req.op_b[31:24]};

  // Stage one registers the partial products and the operator
  always_ff @(posedge clk_i) begin
    if (mult_en_i) begin
      for (int i = 0; i < 2; i++) begin
        for (int j = 0; j < 4; j++) begin
          pp_q[i*4+j] <= a_part[i] * b_part[j];
        end
      end
      op_q <= req.op;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mult_valid_o <= 1'b0;
    end else begin
      mult_valid_o <= mult_en_i;
    end
  end

  // Stage two shifts by 16 per A half and 8 per B byte, then accumulates
  always_comb begin
    product = '0;
    for (int i = 0; i < 2; i++) begin
      for (int j = 0; j < 4; j++) begin
        product = product + (64'(pp_q[i*4+j]) << (16 * i + 8 * j));
      end
    end
  end

  assign mult_result_o = (op_q == md_pkg::MD_OP_MULL) ? product[31:0] : product[63:32];

endmodule

`default_nettype wire

// ==== source/md_div.sv ====
`timescale 1ns/1ns
`default_nettype none

module md_div (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             div_en_i,
  input  logic             data_ind_timing_i,
  md_req_if.dst            req,
  output md_pkg::md_word_t div_result_o,
  output logic             div_valid_o
);

  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_SIGN,
    DIV_FINISH
  } div_state_e;

  div_state_e          state_q, state_d;
  md_pkg::md_div_cnt_t cnt_q, cnt_d;
  logic                by_zero_q, by_zero_d;
  logic                active;

  // Operands latched while idle
  logic                sign_a_q, sign_b_q;
  md_pkg::md_op_e      op_q;
  md_pkg::md_word_t    a_q, b_q;

  md_pkg::md_word_t    numer_q, numer_d;
  md_pkg::md_word_t    denom_q, denom_d;
  md_pkg::md_word_t    quot_q, quot_d;
  md_pkg::md_word_t    rem_q, rem_d;

  // Shared adder with the LSB of each operand acting as carry-in
  logic [32:0]         adder_a, adder_b;
  logic [33:0]         adder_ext;
  md_pkg::md_word_t    adder_out;
  logic                adder_zero;

  logic                is_ge;
  md_pkg::md_word_t    one_shift;
  md_pkg::md_word_t    next_rem;
  md_pkg::md_word_t    next_quot;
  logic                negate;

  assign adder_ext  = {1'b0, adder_a} + {1'b0, adder_b};
  assign adder_out  = adder_ext[32:1];
  assign adder_zero = (adder_out == '0);

  // Unsigned compare of remainder and divisor from the trial subtraction
  always_comb begin
    if (rem_q[31] == denom_q[31]) begin
      is_ge = ~adder_out[31];
    end else begin
      is_ge = rem_q[31];
    end
  end

  assign one_shift = md_pkg::md_word_t'(1) << cnt_q;
  assign next_rem  = is_ge ? adder_out : rem_q;
  assign next_quot = is_ge ? (quot_q | one_shift) : quot_q;

  // Quotient sign flips on mixed signs unless B was zero; remainder follows A
  assign negate = (op_q == md_pkg::MD_OP_DIV) ? ((sign_a_q ^ sign_b_q) & ~by_zero_q) : sign_a_q;

  assign active = div_en_i | (state_q != DIV_IDLE);

  always_comb begin
    state_d   = state_q;
    cnt_d     = cnt_q - md_pkg::md_div_cnt_t'(1);
    by_zero_d = by_zero_q;
    numer_d   = numer_q;
    denom_d   = denom_q;
    quot_d    = quot_q;
    rem_d     = rem_q;
    adder_a   = {32'h0, 1'b1};
    adder_b   = {~req.op_b, 1'b1};

    unique case (state_q)
      DIV_IDLE: begin
        // Adder gives 0 - B, which is zero only when B is zero
        by_zero_d = adder_zero;
        rem_d     = (req.op == md_pkg::MD_OP_DIV) ? '1 : req.op_a;
        state_d   = (adder_zero && !data_ind_timing_i) ? DIV_FINISH : DIV_ABS_A;
      end
      DIV_ABS_A: begin
        adder_b = {~a_q, 1'b1};
        quot_d  = '0;
        numer_d = sign_a_q ? adder_out : a_q;
        state_d = DIV_ABS_B;
      end
      DIV_ABS_B: begin
        adder_b = {~b_q, 1'b1};
        denom_d = sign_b_q ? adder_out : b_q;
        // First partial remainder is the top dividend bit
        rem_d   = {31'h0, numer_q[31]};
        cnt_d   = {md_pkg::MD_DIV_CNT_W{1'b1}};
        state_d = DIV_COMP;
      end
      DIV_COMP: begin
        adder_a = {rem_q, 1'b1};
        adder_b = {~denom_q, 1'b1};
        rem_d   = {next_rem[30:0], numer_q[cnt_d]};
        quot_d  = next_quot;
        if (cnt_q == md_pkg::md_div_cnt_t'(1)) begin
          state_d = DIV_LAST;
        end
      end
      DIV_LAST: begin
        adder_a = {rem_q, 1'b1};
        adder_b = {~denom_q, 1'b1};
        // Only the requested result is kept from here on
        rem_d   = (op_q == md_pkg::MD_OP_DIV) ? next_quot : next_rem;
        state_d = DIV_SIGN;
      end
      DIV_SIGN: begin
        adder_b = {~rem_q, 1'b1};
        rem_d   = negate ? adder_out : rem_q;
        state_d = DIV_FINISH;
      end
      DIV_FINISH: begin
        state_d = DIV_IDLE;
      end
      default: begin
        state_d = DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= DIV_IDLE;
      cnt_q     <= '0;
      by_zero_q <= 1'b0;
    end else if (active) begin
      state_q   <= state_d;
      cnt_q     <= cnt_d;
      by_zero_q <= by_zero_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (active) begin
      numer_q <= numer_d;
      denom_q <= denom_d;
      quot_q  <= quot_d;
      rem_q   <= rem_d;
    end
    // Later bus traffic cannot disturb a running division
    if (state_q == DIV_IDLE) begin
      sign_a_q <= req.op_a[31] & req.sign_mode[0];
      sign_b_q <= req.op_b[31] & req.sign_mode[1];
      op_q     <= req.op;
      a_q      <= req.op_a;
      b_q      <= req.op_b;
    end
  end

  assign div_result_o = rem_q;
  assign div_valid_o  = (state_q == DIV_FINISH);

endmodule

`default_nettype wire

// ==== source/md_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module md_unit (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             mult_en_i,
  input  logic             div_en_i,
  input  logic             data_ind_timing_i,
  input  md_pkg::md_op_e   operator_i,
  input  md_pkg::md_sign_t signed_mode_i,
  input  md_pkg::md_word_t op_a_i,
  input  md_pkg::md_word_t op_b_i,
  output md_pkg::md_word_t mult_result_o,
  output md_pkg::md_word_t div_result_o,
  output logic             mult_valid_o,
  output logic             div_valid_o
);

  md_req_if u_req ();

  // Operand bus shared by both engines
  assign u_req.op        = operator_i;
  assign u_req.sign_mode = signed_mode_i;
  assign u_req.op_a      = op_a_i;
  assign u_req.op_b      = op_b_i;

  md_mult u_mult (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mult_en_i     (mult_en_i),
    .req           (u_req),
    .mult_result_o (mult_result_o),
    .mult_valid_o  (mult_valid_o)
  );

  md_div u_div (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .div_en_i          (div_en_i),
    .data_ind_timing_i (data_ind_timing_i),
    .req               (u_req),
    .div_result_o      (div_result_o),
    .div_valid_o       (div_valid_o)
  );

endmodule

`default_nettype wire

// ==== verification/tb_md_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_md_unit;

  localparam int unsigned SEED         = 32'hf04d8403;
  localparam int          RESET_CYCLES = 10;
  localparam int          N_MULT       = 200;
  localparam int          N_DIV        = 60;
  localparam int          N_OVERLAP    = 20;
  // Multiplies, divisions, divide by zero, overflow and the overlap run
  localparam int          N_OPS        = N_MULT + N_DIV + 4 + 2 + N_OVERLAP + 2;
  localparam int          WATCHDOG     = N_OPS * (md_pkg::MD_DIV_LATENCY + 4) + RESET_CYCLES + 20;

  logic             clk;
  logic             rst_n;
  logic             mult_en;
  logic             div_en;
  logic             dit;
  md_pkg::md_op_e   op_sel;
  md_pkg::md_sign_t sign_mode;
  md_pkg::md_word_t op_a;
  md_pkg::md_word_t op_b;
  md_pkg::md_word_t mult_result;
  md_pkg::md_word_t div_result;
  logic             mult_valid;
  logic             div_valid;

  int unsigned      cycle_cnt = 0;
  int               err_cnt = 0;
  int               pass_cnt = 0;
  int               fail_cnt = 0;
  int               test_err_base = 0;

  // Expected results and the cycle at which each valid pulse is due
  md_pkg::md_word_t mult_exp_q [$];
  int unsigned      mult_due_q [$];
  md_pkg::md_word_t div_exp_q [$];
  int unsigned      div_due_q [$];

  md_unit i_md_unit (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .mult_en_i         (mult_en),
    .div_en_i          (div_en),
    .data_ind_timing_i (dit),
    .operator_i        (op_sel),
    .signed_mode_i     (sign_mode),
    .op_a_i            (op_a),
    .op_b_i            (op_b),
    .mult_result_o     (mult_result),
    .div_result_o      (div_result),
    .mult_valid_o      (mult_valid),
    .div_valid_o       (div_valid)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // Corner values show up often next to plain random words
  function automatic md_pkg::md_word_t rand_operand();
    case ($urandom % 16)
      0: return 32'h0;
      1: return 32'h1;
      2: return 32'hffffffff;
      3: return 32'h80000000;
      4: return 32'h7fffffff;
      default: return $urandom;
    endcase
  endfunction

  // Operands widened to 64 bits by their sign mode and RISC-V rules for a zero divisor
  task automatic compute_expected(input md_pkg::md_op_e op, input md_pkg::md_sign_t sm,
                                  input md_pkg::md_word_t a, input md_pkg::md_word_t b,
                                  output md_pkg::md_word_t res);
    longint wa;
    longint wb;
    longint full;
    wa = sm[0] ? {{32{a[31]}}, a} : {32'h0, a};
    wb = sm[1] ? {{32{b[31]}}, b} : {32'h0, b};
    full = 0;
    case (op)
      md_pkg::MD_OP_MULL, md_pkg::MD_OP_MULH: full = wa * wb;
      md_pkg::MD_OP_DIV: full = (b == '0) ? -1 : wa / wb;
      default: full = (b == '0) ? wa : wa % wb;
    endcase
    res = (op == md_pkg::MD_OP_MULH) ? full[63:32] : full[31:0];
  endtask

  task automatic issue_mult(input md_pkg::md_op_e op, input md_pkg::md_sign_t sm,
                            input md_pkg::md_word_t a, input md_pkg::md_word_t b);
    md_pkg::md_word_t exp;
    @(posedge clk);
    mult_en   <= 1'b1;
    op_sel    <= op;
    sign_mode <= sm;
    op_a      <= a;
    op_b      <= b;
    compute_expected(op, sm, a, b, exp);
    mult_exp_q.push_back(exp);
    mult_due_q.push_back(cycle_cnt + 2);
  endtask

  task automatic start_div(input md_pkg::md_op_e op, input md_pkg::md_sign_t sm,
                           input md_pkg::md_word_t a, input md_pkg::md_word_t b,
                           input logic ind);
    md_pkg::md_word_t exp;
    int unsigned      lat;
    @(posedge clk);
    div_en    <= 1'b1;
    dit       <= ind;
    op_sel    <= op;
    sign_mode <= sm;
    op_a      <= a;
    op_b      <= b;
    compute_expected(op, sm, a, b, exp);
    // Zero divisor exits early unless timing must not depend on data
    lat = (b == '0 && !ind) ? 1 : md_pkg::MD_DIV_LATENCY;
    div_exp_q.push_back(exp);
    div_due_q.push_back(cycle_cnt + 1 + lat);
    @(posedge clk);
    div_en <= 1'b0;
  endtask

  task automatic wait_results(input string what);
    int unsigned n;
    n = 0;
    @(posedge clk);
    mult_en <= 1'b0;
    while ((mult_exp_q.size() != 0 || div_exp_q.size() != 0) &&
           n < md_pkg::MD_DIV_LATENCY + 8) begin
      @(posedge clk);
      n++;
    end
    if (mult_exp_q.size() != 0 || div_exp_q.size() != 0) begin
      $display("Error at %0t ns: %s results did not arrive in time", $time, what);
      err_cnt++;
      mult_exp_q.delete();
      mult_due_q.delete();
      div_exp_q.delete();
      div_due_q.delete();
    end
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err_base) begin
      pass_cnt++;
      $display("Test %s: passed", name);
    end else begin
      fail_cnt++;
      $display("Test %s: failed with %0d errors", name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  always @(posedge clk) begin : mult_monitor
    md_pkg::md_word_t exp;
    int unsigned      due;
    if (mult_valid) begin
      if (mult_exp_q.size() == 0) begin
        $display("Error at %0t ns: mult_valid_o pulsed with no multiply outstanding", $time);
        err_cnt++;
      end else begin
        exp = mult_exp_q.pop_front();
        due = mult_due_q.pop_front();
        if (cycle_cnt != due) begin
          $display("FAILED at %0t ns: mult_valid_o cycle expected %0d, got %0d",
                   $time, due, cycle_cnt);
          err_cnt++;
        end
        if (mult_result !== exp) begin
          $display("FAILED at %0t ns: mult_result_o expected %h, got %h",
                   $time, exp, mult_result);
          err_cnt++;
        end
      end
    end
  end

  always @(posedge clk) begin : div_monitor
    md_pkg::md_word_t exp;
    int unsigned      due;
    if (div_valid) begin
      if (div_exp_q.size() == 0) begin
        $display("Error at %0t ns: div_valid_o pulsed with no division outstanding", $time);
        err_cnt++;
      end else begin
        exp = div_exp_q.pop_front();
        due = div_due_q.pop_front();
        if (cycle_cnt != due) begin
          $display("FAILED at %0t ns: div_valid_o cycle expected %0d, got %0d",
                   $time, due, cycle_cnt);
          err_cnt++;
        end
        if (div_result !== exp) begin
          $display("FAILED at %0t ns: div_result_o expected %h, got %h",
                   $time, exp, div_result);
          err_cnt++;
        end
      end
    end
  end

  initial begin : stimulus
    md_pkg::md_op_e   op;
    md_pkg::md_word_t a;
    md_pkg::md_word_t b;
    void'($urandom(SEED));
    rst_n     <= 1'b0;
    mult_en   <= 1'b0;
    div_en    <= 1'b0;
    dit       <= 1'b0;
    op_sel    <= md_pkg::MD_OP_MULL;
    sign_mode <= 2'b00;
    op_a      <= '0;
    op_b      <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    repeat (20) begin
      @(posedge clk);
      if (mult_valid !== 1'b0) begin
        $display("FAILED at %0t ns: mult_valid_o expected 0, got %b", $time, mult_valid);
        err_cnt++;
      end
      if (div_valid !== 1'b0) begin
        $display("FAILED at %0t ns: div_valid_o expected 0, got %b", $time, div_valid);
        err_cnt++;
      end
    end
    end_test("reset state");

    for (int i = 0; i < N_MULT; i++) begin
      op = ($urandom % 2 == 0) ? md_pkg::MD_OP_MULL : md_pkg::MD_OP_MULH;
      a  = rand_operand();
      b  = rand_operand();
      issue_mult(op, md_pkg::md_sign_t'($urandom % 4), a, b);
    end
    wait_results("multiply");
    end_test("back-to-back multiplies");

    for (int i = 0; i < N_DIV; i++) begin
      op = ($urandom % 2 == 0) ? md_pkg::MD_OP_DIV : md_pkg::MD_OP_REM;
      a  = rand_operand();
      b  = rand_operand();
      while (b == '0) begin
        b = rand_operand();
      end
      start_div(op, md_pkg::md_sign_t'($urandom % 4), a, b, 1'($urandom % 2));
      wait_results("division");
    end
    end_test("random divisions");

    // Bit 0 picks REM over DIV, bit 1 forces the full division length
    a = rand_operand();
    for (int k = 0; k < 4; k++) begin
      op = k[0] ? md_pkg::MD_OP_REM : md_pkg::MD_OP_DIV;
      start_div(op, md_pkg::md_sign_t'($urandom % 4), a, 32'h0, k[1]);
      wait_results("divide by zero");
    end
    end_test("divide by zero");

    start_div(md_pkg::MD_OP_DIV, 2'b11, 32'h80000000, 32'hffffffff, 1'b0);
    wait_results("signed overflow");
    start_div(md_pkg::MD_OP_REM, 2'b11, 32'h80000000, 32'hffffffff, 1'b0);
    wait_results("signed overflow");
    end_test("signed overflow");

    op = ($urandom % 2 == 0) ? md_pkg::MD_OP_DIV : md_pkg::MD_OP_REM;
    a  = rand_operand();
    b  = 32'h3 + ($urandom % 1000);
    start_div(op, md_pkg::md_sign_t'($urandom % 4), a, b, 1'b0);
    for (int i = 0; i < N_OVERLAP; i++) begin
      op = ($urandom % 2 == 0) ? md_pkg::MD_OP_MULL : md_pkg::MD_OP_MULH;
      a  = rand_operand();
      b  = rand_operand();
      issue_mult(op, md_pkg::md_sign_t'($urandom % 4), a, b);
      // Second division request while the divider is busy
      div_en <= (i == 6);
    end
    wait_results("overlap");
    repeat (md_pkg::MD_DIV_LATENCY + 4) @(posedge clk);
    end_test("overlap and ignored enable");

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== md_unit.f ====
source/md_pkg.sv
source/md_req_if.sv
source/md_mult.sv
source/md_div.sv
source/md_unit.sv
verification/tb_md_unit.sv

// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_md_unit
FILELIST   = md_unit.f
BUILD_DIR  = obj_dir
PASS_MSG   = Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
